// ==== hw/data_rom.hex ====
// one 128-bit word per line, address 0 first, each 32-bit lane carries the address
c0de0000a5a5ff000f0f00003c3cff00
c0de0001a5a5fe010f0f00013c3cfe01
c0de0002a5a5fd020f0f00023c3cfd02
c0de0003a5a5fc030f0f00033c3cfc03
c0de0004a5a5fb040f0f00043c3cfb04
c0de0005a5a5fa050f0f00053c3cfa05
c0de0006a5a5f9060f0f00063c3cf906
c0de0007a5a5f8070f0f00073c3cf807
c0de0008a5a5f7080f0f00083c3cf708
c0de0009a5a5f6090f0f00093c3cf609
c0de000aa5a5f50a0f0f000a3c3cf50a
c0de000ba5a5f40b0f0f000b3c3cf40b
c0de000ca5a5f30c0f0f000c3c3cf30c
c0de000da5a5f20d0f0f000d3c3cf20d
c0de000ea5a5f10e0f0f000e3c3cf10e
c0de000fa5a5f00f0f0f000f3c3cf00f
c0de0010a5a5ef100f0f00103c3cef10
c0de0011a5a5ee110f0f00113c3cee11
c0de0012a5a5ed120f0f00123c3ced12
c0de0013a5a5ec130f0f00133c3cec13
c0de0014a5a5eb140f0f00143c3ceb14
c0de0015a5a5ea150f0f00153c3cea15
c0de0016a5a5e9160f0f00163c3ce916
c0de0017a5a5e8170f0f00173c3ce817
c0de0018a5a5e7180f0f00183c3ce718
c0de0019a5a5e6190f0f00193c3ce619
c0de001aa5a5e51a0f0f001a3c3ce51a
c0de001ba5a5e41b0f0f001b3c3ce41b
c0de001ca5a5e31c0f0f001c3c3ce31c
c0de001da5a5e21d0f0f001d3c3ce21d
c0de001ea5a5e11e0f0f001e3c3ce11e
c0de001fa5a5e01f0f0f001f3c3ce01f
c0de0020a5a5df200f0f00203c3cdf20
c0de0021a5a5de210f0f00213c3cde21
c0de0022a5a5dd220f0f00223c3cdd22
c0de0023a5a5dc230f0f00233c3cdc23
c0de0024a5a5db240f0f00243c3cdb24
c0de0025a5a5da250f0f00253c3cda25
c0de0026a5a5d9260f0f00263c3cd926
c0de0027a5a5d8270f0f00273c3cd827
c0de0028a5a5d7280f0f00283c3cd728
c0de0029a5a5d6290f0f00293c3cd629
c0de002aa5a5d52a0f0f002a3c3cd52a
c0de002ba5a5d42b0f0f002b3c3cd42b
c0de002ca5a5d32c0f0f002c3c3cd32c
c0de002da5a5d22d0f0f002d3c3cd22d
c0de002ea5a5d12e0f0f002e3c3cd12e
c0de002fa5a5d02f0f0f002f3c3cd02f

// ==== sim/xfer_patterns.txt ====
# code(hex) read_mode(1 real, 0 pseudo) length start_addr(dec)
# start_addr only matters for real reads of region codes
0 1 4 0
3 1 3 4
3 1 3 8
3 1 3 4
6 1 4 32
6 1 4 36
6 1 4 40
6 1 4 32
5 1 4 12
4 1 4 16
7 1 4 24
2 1 4 0
1 1 4 0
9 1 8 0
4 1 4 20
6 0 4 0
6 1 3 36
6 1 4 40
3 0 3 0
3 1 2 8
3 1 3 4
7 1 4 28
f 1 8 0
0 1 4 0

// ==== compile.f ====
+incdir+hw
hw/chip_test_pkg.sv
hw/chip_reset_seq.sv
hw/xfer_ctrl.sv
hw/region_addr.sv
hw/data_rom.sv
hw/chip_test_top.sv
sim/tb_chip_test.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the chip test bench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f \
    --top-module tb_chip_test -Mdir obj_dir

./obj_dir/Vtb_chip_test > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation finished without failures"

// ==== sim/tb_chip_test.sv ====
`timescale 1ns/1ps
`include "chip_test_params.svh"

module tb_chip_test;

    localparam int TIMEOUT_CYC = 40;
    localparam int HOLD_BLOCKS = 1;
    localparam int WA_NEEDED   = 4 * HOLD_BLOCKS + 2;   // weiaddr headers to release the hold

    logic                  clk;
    logic                  rst_n;
    logic                  config_req;
    logic                  rdwr_sel;
    logic [`CT_DATA_W-1:0] spi_data_in;
    logic                  seq_start;
    logic [3:0]            block_limit;
    logic [`CT_DATA_W-1:0] spi_data_out;
    logic                  spi_cs_n;
    logic                  oe_n;
    logic                  chip_rst_n;
    logic                  sw_clk;

    logic [`CT_DATA_W-1:0] rom_img [`CT_ROM_DEPTH];   // expected words
    int mismatches;
    int failures;
    int wa_sent;
    int n_pat;

    chip_test_top chip_test_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .config_req   (config_req),
        .rdwr_sel     (rdwr_sel),
        .spi_data_in  (spi_data_in),
        .seq_start    (seq_start),
        .block_limit  (block_limit),
        .spi_data_out (spi_data_out),
        .spi_cs_n     (spi_cs_n),
        .oe_n         (oe_n),
        .chip_rst_n   (chip_rst_n),
        .sw_clk       (sw_clk)
    );

    always #2 clk = ~clk;

    // codes that own a ROM region
    function automatic logic is_region_code(input logic [3:0] code);
        case (code)
            4'd0, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [`CT_DATA_W-1:0] make_header(input logic [3:0] code);
        logic [`CT_DATA_W-1:0] w;
        w = {$urandom, $urandom, $urandom, $urandom};
        w[`CT_CODE_LSB +: 4] = code;
        return w;
    endfunction

    // ============================================================
    // one header and its burst
    // ============================================================
    task automatic run_transfer(input logic [3:0] code, input logic rd,
                                input int exp_len, input int exp_start);
        int                    wait_cyc;
        int                    idx;
        logic [`CT_DATA_W-1:0] exp_word;
        @(negedge clk);
        spi_data_in = make_header(code);
        rdwr_sel    = rd;
        config_req  = 1'b1;
        @(negedge clk);
        config_req = 1'b0;
        if (code == 4'd3) wa_sent++;
        wait_cyc = 0;
        while (spi_cs_n && wait_cyc < TIMEOUT_CYC) begin
            @(negedge clk);
            wait_cyc++;
        end
        if (spi_cs_n) begin
            $display("pattern %0d: chip select never went low", n_pat);
            failures++;
            return;
        end
        idx = 0;
        while (!spi_cs_n && idx < TIMEOUT_CYC) begin
            exp_word = (rd && is_region_code(code)) ? rom_img[exp_start + idx] : '0;
            if (spi_data_out !== exp_word) begin
                $display("mismatch spi_data_out pattern %0d word %0d: expected %h, got %h",
                         n_pat, idx, exp_word, spi_data_out);
                mismatches++;
            end
            if (oe_n !== 1'b0) begin
                $display("mismatch oe_n pattern %0d word %0d: expected 0, got %h",
                         n_pat, idx, oe_n);
                mismatches++;
            end
            idx++;
            @(negedge clk);
        end
        if (!spi_cs_n) begin
            $display("pattern %0d: chip select stuck low", n_pat);
            failures++;
            return;
        end
        if (idx != exp_len) begin
            $display("mismatch burst length pattern %0d: expected %0h, got %0h",
                     n_pat, exp_len, idx);
            mismatches++;
        end
        if (oe_n !== 1'b0) begin   // one tail cycle
            $display("mismatch oe_n tail pattern %0d: expected 0, got %h", n_pat, oe_n);
            mismatches++;
        end
        @(negedge clk);
        if (oe_n !== 1'b1) begin
            $display("mismatch oe_n after tail pattern %0d: expected 1, got %h", n_pat, oe_n);
            mismatches++;
        end
    endtask

    // ============================================================
    // reset sequencer
    // ============================================================
    task automatic pulse_seq_start();
        @(negedge clk);
        seq_start = 1'b1;
        @(negedge clk);
        seq_start = 1'b0;
    endtask

    task automatic check_reset_pulse();
        int wait_cyc;
        int low_cyc;
        pulse_seq_start();
        if (sw_clk !== 1'b0) begin
            $display("mismatch sw_clk after start: expected 0, got %h", sw_clk);
            mismatches++;
        end
        wait_cyc = 0;
        while (chip_rst_n && wait_cyc < TIMEOUT_CYC) begin
            @(negedge clk);
            wait_cyc++;
        end
        if (chip_rst_n) begin
            $display("chip reset never went low after seq_start");
            failures++;
            return;
        end
        if (wait_cyc != `CT_RST_WAIT_SW || sw_clk !== 1'b0) begin
            $display("mismatch reset delay: expected %0h, got %0h (sw_clk %h)",
                     `CT_RST_WAIT_SW, wait_cyc, sw_clk);
            mismatches++;
        end
        low_cyc = 0;
        while (!chip_rst_n && low_cyc < TIMEOUT_CYC) begin
            @(negedge clk);
            low_cyc++;
        end
        if (!chip_rst_n) begin
            $display("chip reset stuck low");
            failures++;
            return;
        end
        if (low_cyc != 1 + `CT_RST_WAIT_LOW) begin
            $display("mismatch chip_rst_n low cycles: expected %0h, got %0h",
                     1 + `CT_RST_WAIT_LOW, low_cyc);
            mismatches++;
        end
        @(negedge clk);
        if (sw_clk !== 1'b1) begin
            $display("mismatch sw_clk after release: expected 1, got %h", sw_clk);
            mismatches++;
        end
    endtask

    task automatic check_start_ignored();
        int   cyc;
        logic bad;
        pulse_seq_start();
        bad = 1'b0;
        for (cyc = 0; cyc < 12; cyc++) begin
            if (chip_rst_n !== 1'b1 || sw_clk !== 1'b1) bad = 1'b1;
            @(negedge clk);
        end
        if (bad) begin
            $display("seq_start was not ignored while the sequencer was holding");
            failures++;
        end
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        int         fd;
        int         n;
        int         rd;
        int         len;
        int         start;
        int         seed_val;
        logic [3:0] code;
        logic       ignore_done;
        string      line;
        seed_val    = $urandom(32211);
        clk         = 1'b0;
        rst_n       = 1'b0;
        config_req  = 1'b0;
        rdwr_sel    = 1'b0;
        spi_data_in = '0;
        seq_start   = 1'b0;
        block_limit = 4'(HOLD_BLOCKS);
        mismatches  = 0;
        failures    = 0;
        wa_sent     = 0;
        n_pat       = 0;
        ignore_done = 1'b0;
        $readmemh("hw/data_rom.hex", rom_img);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (spi_cs_n !== 1'b1 || oe_n !== 1'b1 || chip_rst_n !== 1'b1 || sw_clk !== 1'b0
            || spi_data_out !== '0) begin
            $display("mismatch idle outputs cs/oe/rst/sw/data: expected 1 1 1 0 0, ",
                     "got %h %h %h %h %h", spi_cs_n, oe_n, chip_rst_n, sw_clk, spi_data_out);
            mismatches++;
        end
        check_reset_pulse();

        fd = $fopen("sim/xfer_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            failures++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n == 0 || line.getc(0) == "#") continue;
                n = $sscanf(line, "%h %d %d %d", code, rd, len, start);
                if (n <= 0) continue;        // blank line
                if (n != 4) begin
                    $display("malformed pattern line: %s", line);
                    failures++;
                    continue;
                end
                run_transfer(code, rd[0], len, start);
                n_pat++;
                // one header short of the limit, so the hold must still be on
                if (wa_sent == WA_NEEDED - 1 && !ignore_done) begin
                    check_start_ignored();
                    ignore_done = 1'b1;
                end
            end
            $fclose(fd);
        end
        if (n_pat == 0 || wa_sent < WA_NEEDED || !ignore_done) begin
            $display("too few transfers were run to release the sequencer hold");
            failures++;
        end
        check_reset_pulse();   // hold is over, so this one must run

        $display("errors: %0d mismatches, %0d other failures over %0d transfers",
                 mismatches, failures, n_pat);
        if (mismatches == 0 && failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== hw/chip_test_top.sv ====
`timescale 1ns/1ps
`include "chip_test_params.svh"

module chip_test_top import chip_test_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  config_req,
    input  logic                  rdwr_sel,
    input  logic [`CT_DATA_W-1:0] spi_data_in,   // header from the chip
    input  logic                  seq_start,
    input  logic [3:0]            block_limit,
    output logic [`CT_DATA_W-1:0] spi_data_out,
    output logic                  spi_cs_n,
    output logic                  oe_n,
    output logic                  chip_rst_n,
    output logic                  sw_clk
);

    ct_cfg_evt_t           cfg_evt;
    ct_rd_req_t            rd_req;
    logic [`CT_ADDR_W-1:0] rom_addr;
    logic                  rom_en;
    logic [`CT_DATA_W-1:0] rom_data;

    // ============================================================
    // transfer path
    // ============================================================
    xfer_ctrl xfer_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .config_req   (config_req),
        .rdwr_sel     (rdwr_sel),
        .hdr          (spi_data_in),
        .rom_data     (rom_data),
        .cfg_evt      (cfg_evt),
        .rd_req       (rd_req),
        .spi_data_out (spi_data_out),
        .spi_cs_n     (spi_cs_n),
        .oe_n         (oe_n)
    );

    region_addr region_addr_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_evt  (cfg_evt),
        .rd_req   (rd_req),
        .rom_addr (rom_addr),
        .rom_en   (rom_en)
    );

    data_rom data_rom_inst (
        .clk  (clk),
        .en   (rom_en),
        .addr (rom_addr),
        .data (rom_data)
    );

    // chip reset and clock switch
    chip_reset_seq chip_reset_seq_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .seq_start   (seq_start),
        .block_limit (block_limit),
        .cfg_evt     (cfg_evt),
        .sw_clk      (sw_clk),
        .chip_rst_n  (chip_rst_n)
    );

endmodule

// ==== hw/data_rom.sv ====
`timescale 1ns/1ps
`include "chip_test_params.svh"

module data_rom (
    input  logic                  clk,
    input  logic                  en,
    input  logic [`CT_ADDR_W-1:0] addr,
    output logic [`CT_DATA_W-1:0] data
);

    logic [`CT_DATA_W-1:0] mem [`CT_ROM_DEPTH];

    initial begin
        $readmemh("hw/data_rom.hex", mem);
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (en) begin
            data <= mem[addr];
        end
    end

endmodule

// ==== hw/region_addr.sv ====
`timescale 1ns/1ps
`include "chip_test_params.svh"

module region_addr import chip_test_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ct_cfg_evt_t           cfg_evt,
    input  ct_rd_req_t            rd_req,
    output logic [`CT_ADDR_W-1:0] rom_addr,
    output logic                  rom_en
);

    localparam int NR = `CT_NUM_REGIONS;

    // ============================================================
    // region table, one entry per read code
    // ============================================================
    localparam ct_code_e REGION_CODE [NR] = '{
        CODE_CFG, CODE_WEIADDR, CODE_FLGWEI, CODE_WEI, CODE_FLGACT, CODE_ACT
    };
    localparam int REGION_START [NR] = '{
        `CT_BASE_CFG, `CT_BASE_WEIADDR, `CT_BASE_FLGWEI,
        `CT_BASE_WEI, `CT_BASE_FLGACT, `CT_BASE_ACT
    };
    localparam int REGION_BLKS [NR] = '{
        `CT_BLK_CFG, `CT_BLK_WEIADDR, `CT_BLK_FLGWEI,
        `CT_BLK_WEI, `CT_BLK_FLGACT, `CT_BLK_ACT
    };

    logic [`CT_ADDR_W-1:0] base_q    [NR];
    logic [`CT_ADDR_W-1:0] base_next [NR];
    logic [`CT_ADDR_W-1:0] sel_base;
    logic [`CT_ADDR_W-1:0] rd_addr_q;
    logic                  base_step;

    // one slot on, back to the start at the region end
    always_comb begin
        for (int i = 0; i < NR; i++) begin
            base_next[i] = base_q[i] + `CT_ADDR_W'(`CT_SLOT_WORDS);
            if (base_next[i] >= `CT_ADDR_W'(REGION_START[i] + `CT_SLOT_WORDS * REGION_BLKS[i]))
                base_next[i] = `CT_ADDR_W'(REGION_START[i]);
        end
    end

    always_comb begin
        sel_base = '0;                     // non-region codes read from 0
        for (int i = 0; i < NR; i++) begin
            if (cfg_evt.code == REGION_CODE[i]) sel_base = base_q[i];
        end
    end

    assign base_step = rd_req.done && rd_req.real_rd;   // pseudo reads leave bases alone

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NR; i++) base_q[i] <= `CT_ADDR_W'(REGION_START[i]);
        end else if (base_step) begin
            for (int i = 0; i < NR; i++) begin
                if (rd_req.code == REGION_CODE[i]) base_q[i] <= base_next[i];
            end
        end
    end

    // ============================================================
    // running read address
    // ============================================================
    // enable runs one cycle ahead of the data for the registered ROM
    assign rom_en = rd_req.start || (rd_req.advance && !rd_req.done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr_q <= '0;
        end else if (cfg_evt.valid) begin
            rd_addr_q <= sel_base;
        end else if (rom_en) begin
            rd_addr_q <= rd_addr_q + 1'b1;
        end
    end

    assign rom_addr = rd_addr_q;

endmodule

// ==== hw/xfer_ctrl.sv ====
`timescale 1ns/1ps
`include "chip_test_params.svh"

module xfer_ctrl import chip_test_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  config_req,
    input  logic                  rdwr_sel,       // 1 real read, 0 pseudo read
    input  logic [`CT_DATA_W-1:0] hdr,
    input  logic [`CT_DATA_W-1:0] rom_data,
    output ct_cfg_evt_t           cfg_evt,
    output ct_rd_req_t            rd_req,
    output logic [`CT_DATA_W-1:0] spi_data_out,
    output logic                  spi_cs_n,
    output logic                  oe_n
);

    logic                 cfg_req_q;
    ct_xfer_state_e       state_q;
    ct_xfer_state_e       state_nxt;
    ct_code_e             code_q;
    logic                 rd_mode_q;   // rdwr_sel taken with the header
    logic                 patch_q;
    logic [`CT_LEN_W-1:0] len_q;
    logic [`CT_LEN_W-1:0] word_cnt_q;
    logic [`CT_LEN_W-1:0] len_full;
    logic [`CT_LEN_W-1:0] len_dec;
    logic                 oe_tail_q;   // keeps oe one cycle past the data
    logic                 rd_code;
    logic                 in_rd;
    logic                 last_word;

    assign in_rd     = (state_q == XFER_RD_DATA);
    assign last_word = in_rd && (word_cnt_q == len_q - 1'b1);
    assign rd_code   = code_q inside {CODE_CFG, CODE_WEIADDR, CODE_FLGWEI,
                                      CODE_WEI, CODE_FLGACT, CODE_ACT};

    // ============================================================
    // length decode
    // ============================================================
    always_comb begin
        case (code_q)
            CODE_CFG:     len_full = `CT_LEN_CFG;
            CODE_WEIADDR: len_full = `CT_LEN_WEIADDR;
            CODE_FLGWEI:  len_full = `CT_LEN_FLGWEI;
            CODE_WEI:     len_full = `CT_LEN_WEI;
            CODE_FLGACT:  len_full = `CT_LEN_FLGACT;
            CODE_ACT:     len_full = `CT_LEN_ACT;
            CODE_OFM:     len_full = `CT_LEN_OFM;
            CODE_FLGOFM:  len_full = `CT_LEN_FLGOFM;
            default:      len_full = `CT_LEN_DEFAULT;
        endcase
        len_dec = len_full;
        if (rd_code && rd_mode_q && patch_q)      // shortened after a pseudo read
            len_dec = len_full - `CT_LEN_W'(`CT_PATCH_WORDS);
    end

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            XFER_IDLE:    if (cfg_req_q) state_nxt = XFER_CONFIG;
            XFER_CONFIG:  state_nxt = XFER_WAIT;
            XFER_WAIT:    state_nxt = XFER_RD_DATA;
            XFER_RD_DATA: if (last_word) state_nxt = XFER_IDLE;
            default:      state_nxt = XFER_IDLE;
        endcase
    end

    // ============================================================
    // state and counters
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_req_q  <= 1'b0;
            state_q    <= XFER_IDLE;
            code_q     <= CODE_EMPTY;
            rd_mode_q  <= 1'b0;
            patch_q    <= 1'b0;
            len_q      <= '0;
            word_cnt_q <= '0;
            oe_tail_q  <= 1'b0;
        end else begin
            cfg_req_q <= config_req;
            state_q   <= state_nxt;
            oe_tail_q <= in_rd;
            if (state_q == XFER_IDLE && cfg_req_q) begin    // header capture
                code_q    <= ct_code_e'(hdr[`CT_CODE_LSB +: 4]);
                rd_mode_q <= rdwr_sel;
            end
            if (state_q == XFER_CONFIG) len_q <= len_dec;
            word_cnt_q <= in_rd ? word_cnt_q + 1'b1 : '0;
            if (last_word && !rd_mode_q)
                patch_q <= 1'b1;
            else if (state_q == XFER_CONFIG && rd_mode_q)
                patch_q <= 1'b0;
        end
    end

    // ============================================================
    // outputs
    // ============================================================
    assign cfg_evt.valid  = (state_q == XFER_CONFIG);
    assign cfg_evt.code   = code_q;

    assign rd_req.start   = (state_q == XFER_WAIT);
    assign rd_req.done    = last_word;
    assign rd_req.real_rd = rd_mode_q;
    assign rd_req.code    = code_q;
    assign rd_req.advance = in_rd;

    assign spi_cs_n     = !in_rd;
    assign oe_n         = !(in_rd || oe_tail_q);
    assign spi_data_out = (in_rd && rd_mode_q && rd_code) ? rom_data : '0;

endmodule

// ==== hw/chip_reset_seq.sv ====
`timescale 1ns/1ps
`include "chip_test_params.svh"

module chip_reset_seq import chip_test_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        seq_start,
    input  logic [3:0]  block_limit,
    input  ct_cfg_evt_t cfg_evt,
    output logic        sw_clk,
    output logic        chip_rst_n
);

    ct_rst_state_e state_q;
    logic [2:0]    wait_cnt_q;
    logic [6:0]    wa_cnt_q;     // weiaddr headers seen while holding
    logic [6:0]    wa_limit;

    assign wa_limit = {1'b0, block_limit, 2'b00} + 7'd2;   // 4 x limit + 2

    // ============================================================
    // sequencer, outputs registered with the state
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= RST_IDLE;
            wait_cnt_q <= '0;
            sw_clk     <= 1'b0;
            chip_rst_n <= 1'b1;
        end else begin
            case (state_q)
                RST_IDLE: if (seq_start) begin
                    state_q    <= RST_SW_LOW;
                    wait_cnt_q <= '0;
                    sw_clk     <= 1'b0;   // switch chip clock away first
                end
                RST_SW_LOW: if (wait_cnt_q == 3'(`CT_RST_WAIT_SW - 1)) begin
                    state_q    <= RST_PULSE;
                    wait_cnt_q <= '0;
                    chip_rst_n <= 1'b0;
                end else begin
                    wait_cnt_q <= wait_cnt_q + 3'd1;
                end
                RST_PULSE: if (wait_cnt_q == 3'(`CT_RST_WAIT_LOW)) begin
                    state_q    <= RST_RELEASE;
                    chip_rst_n <= 1'b1;
                end else begin
                    wait_cnt_q <= wait_cnt_q + 3'd1;
                end
                RST_RELEASE: begin
                    state_q <= RST_HOLD;
                    sw_clk  <= 1'b1;      // clock back on after reset release
                end
                RST_HOLD: if (wa_cnt_q >= wa_limit) state_q <= RST_IDLE;
                default: state_q <= RST_IDLE;
            endcase
        end
    end

    // weiaddr block counter, only live while holding
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wa_cnt_q <= '0;
        end else if (state_q != RST_HOLD) begin
            wa_cnt_q <= '0;
        end else if (cfg_evt.valid && cfg_evt.code == CODE_WEIADDR) begin
            wa_cnt_q <= wa_cnt_q + 7'd1;
        end
    end

endmodule

// ==== hw/chip_test_pkg.sv ====
package chip_test_pkg;

    // data type code carried in the header word
    typedef enum logic [3:0] {
        CODE_CFG     = 4'd0,
        CODE_FLGOFM  = 4'd1,
        CODE_OFM     = 4'd2,
        CODE_WEIADDR = 4'd3,
        CODE_WEI     = 4'd4,
        CODE_FLGWEI  = 4'd5,
        CODE_ACT     = 4'd6,
        CODE_FLGACT  = 4'd7,
        CODE_EMPTY   = 4'd15
    } ct_code_e;

    // header taken, one cycle
    typedef struct packed {
        logic     valid;
        ct_code_e code;
    } ct_cfg_evt_t;

    // transfer phase info for the address walker
    typedef struct packed {
        logic     start;    // cycle before first word
        logic     done;     // last word
        logic     real_rd;  // 0 = pseudo read
        ct_code_e code;
        logic     advance;  // one per streamed word
    } ct_rd_req_t;

    typedef enum logic [2:0] {
        XFER_IDLE, XFER_CONFIG, XFER_WAIT, XFER_RD_DATA
    } ct_xfer_state_e;

    typedef enum logic [2:0] {
        RST_IDLE, RST_SW_LOW, RST_PULSE, RST_RELEASE, RST_HOLD
    } ct_rst_state_e;

endpackage

// ==== hw/chip_test_params.svh ====
`ifndef CHIP_TEST_PARAMS_SVH
`define CHIP_TEST_PARAMS_SVH

// ============================================================
// widths
// ============================================================
`define CT_DATA_W       128
`define CT_ADDR_W       6
`define CT_ROM_DEPTH    48
`define CT_LEN_W        8
`define CT_CODE_LSB     18     // code field is hdr[21:18]
`define CT_PATCH_WORDS  1      // taken off the read after a pseudo read

// read length per code, in 128-bit words
`define CT_LEN_CFG      4
`define CT_LEN_WEIADDR  3
`define CT_LEN_FLGWEI   4
`define CT_LEN_WEI      4
`define CT_LEN_FLGACT   4
`define CT_LEN_ACT      4
`define CT_LEN_OFM      4
`define CT_LEN_FLGOFM   4
`define CT_LEN_DEFAULT  8      // unknown codes

// ============================================================
// ROM regions
// ============================================================
`define CT_NUM_REGIONS  6
`define CT_SLOT_WORDS   4      // same slot for every region

`define CT_BLK_CFG      1
`define CT_BLK_WEIADDR  2
`define CT_BLK_FLGWEI   1
`define CT_BLK_WEI      2
`define CT_BLK_FLGACT   2
`define CT_BLK_ACT      3

`define CT_BASE_CFG     0
`define CT_BASE_WEIADDR 4
`define CT_BASE_FLGWEI  12
`define CT_BASE_WEI     16
`define CT_BASE_FLGACT  24
`define CT_BASE_ACT     32     // act region tops out at 44

// reset sequencer waits, in clk cycles
`define CT_RST_WAIT_SW  2
`define CT_RST_WAIT_LOW 1

`endif
